/* mvu_csr_pkg.sv */
`default_nettype none

package mvu_csr_pkg;

        localparam int XLEN          = 32;
        localparam int HART_ID_WIDTH = 3;

        typedef logic [11:0]              csr_addr_t;
        typedef logic [XLEN-1:0]          csr_data_t;
        typedef logic [2:0]               csr_op_t;
        typedef logic [HART_ID_WIDTH-1:0] hart_id_t;

        localparam csr_op_t CSR_OP_NONE  = 3'd0;   // No access
        localparam csr_op_t CSR_OP_WRITE = 3'd1;
        localparam csr_op_t CSR_OP_SET   = 3'd2;
        localparam csr_op_t CSR_OP_CLEAR = 3'd3;
        localparam csr_op_t CSR_OP_READ  = 3'd4;   // Data only, no update

        localparam csr_addr_t CSR_MVU_WBASEPTR  = 12'hF20;
        localparam csr_addr_t CSR_MVU_IBASEPTR  = 12'hF21;
        localparam csr_addr_t CSR_MVU_OBASEPTR  = 12'hF22;
        localparam csr_addr_t CSR_MVU_WLENGTH   = 12'hF23;
        localparam csr_addr_t CSR_MVU_PRECISION = 12'hF24;
        localparam csr_addr_t CSR_MVU_COMMAND   = 12'hF25;
        localparam csr_addr_t CSR_MVU_STATUS    = 12'hF26;
        localparam csr_addr_t CSR_MVU_IE        = 12'hF27;

        // New register value for one CSR op
        function automatic csr_data_t csr_apply(
                input csr_op_t   op,
                input csr_data_t old_val,
                input csr_data_t wdata
        );
                csr_data_t new_val;
                case (op)
                        CSR_OP_WRITE: new_val = wdata;
                        CSR_OP_SET:   new_val = old_val | wdata;
                        CSR_OP_CLEAR: new_val = old_val & ~wdata;
                        default:      new_val = old_val;   // NONE, READ and unused codes
                endcase
                return new_val;
        endfunction

endpackage

`default_nettype wire

/* csr_access_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface csr_access_if
        import mvu_csr_pkg::*;
();

        csr_op_t   op;
        csr_addr_t addr;
        csr_data_t wdata;
        csr_data_t rdata;      // Value before this cycle's update
        logic      illegal;

        modport requester (
                output op,
                output addr,
                output wdata,
                input  rdata,
                input  illegal
        );

        modport responder (
                input  op,
                input  addr,
                input  wdata,
                output rdata,
                output illegal
        );

endinterface

`default_nettype wire

/* hart_csr_router.sv */
`timescale 1ns/10ps
`default_nettype none

module hart_csr_router
        import mvu_csr_pkg::*;
#(
        parameter int unsigned NUM_HARTS = 4
) (
        input  wire hart_id_t   hart_id_i,
        input  wire csr_op_t    csr_op_i,
        input  wire csr_addr_t  csr_addr_i,
        input  wire csr_data_t  csr_wdata_i,
        output csr_data_t       csr_rdata_o,
        output logic            csr_illegal_o,
        csr_access_if.requester hart_bus [NUM_HARTS]
);

        csr_data_t            rdata_sigs [NUM_HARTS];
        logic [NUM_HARTS-1:0] illegal_sigs;
        logic                 hart_valid;

        assign hart_valid = (hart_id_i < NUM_HARTS);

        for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
                // Idle harts see no op
                assign hart_bus[h].op    = (hart_id_i == hart_id_t'(h)) ? csr_op_i
                                                                        : CSR_OP_NONE;
                assign hart_bus[h].addr  = csr_addr_i;
                assign hart_bus[h].wdata = csr_wdata_i;

                assign rdata_sigs[h]   = hart_bus[h].rdata;
                assign illegal_sigs[h] = hart_bus[h].illegal;
        end

        always_comb begin
                csr_rdata_o   = '0;
                csr_illegal_o = 1'b0;
                for (int h = 0; h < NUM_HARTS; h++) begin
                        if (hart_id_i == hart_id_t'(h)) begin
                                csr_rdata_o   = rdata_sigs[h];
                                csr_illegal_o = illegal_sigs[h];
                        end
                end
                // No such hart
                if (!hart_valid && (csr_op_i != CSR_OP_NONE)) begin
                        csr_illegal_o = 1'b1;
                end
        end

endmodule

`default_nettype wire

/* mvu_cfg_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module mvu_cfg_regs
        import mvu_csr_pkg::*;
(
        input  wire             clk,
        input  wire             reset_i,
        input  wire csr_op_t    op_i,
        input  wire csr_addr_t  addr_i,
        input  wire csr_data_t  wdata_i,
        output logic            hit_o,
        output csr_data_t       rdata_o,
        output logic            mvu_start_o,
        output csr_data_t       wbaseptr_o,
        output csr_data_t       ibaseptr_o,
        output csr_data_t       obaseptr_o,
        output csr_data_t       wlength_o,
        output csr_data_t       precision_o
);

        csr_data_t wbaseptr_q;
        csr_data_t ibaseptr_q;
        csr_data_t obaseptr_q;
        csr_data_t wlength_q;
        csr_data_t precision_q;
        csr_data_t command_q;
        csr_data_t command_new;
        logic      command_wr;
        logic      start_q;

        assign command_new = csr_apply(op_i, command_q, wdata_i);
        assign command_wr  = (addr_i == CSR_MVU_COMMAND) &&
                             ((op_i == CSR_OP_WRITE) || (op_i == CSR_OP_SET) ||
                              (op_i == CSR_OP_CLEAR));

        always_comb begin
                hit_o   = 1'b1;
                rdata_o = '0;
                case (addr_i)
                        CSR_MVU_WBASEPTR:  rdata_o = wbaseptr_q;
                        CSR_MVU_IBASEPTR:  rdata_o = ibaseptr_q;
                        CSR_MVU_OBASEPTR:  rdata_o = obaseptr_q;
                        CSR_MVU_WLENGTH:   rdata_o = wlength_q;
                        CSR_MVU_PRECISION: rdata_o = precision_q;
                        CSR_MVU_COMMAND:   rdata_o = command_q;
                        default:           hit_o   = 1'b0;
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        wbaseptr_q  <= '0;
                        ibaseptr_q  <= '0;
                        obaseptr_q  <= '0;
                        wlength_q   <= '0;
                        precision_q <= '0;
                        command_q   <= '0;
                        start_q     <= 1'b0;
                end else begin
                        case (addr_i)
                                CSR_MVU_WBASEPTR:
                                        wbaseptr_q <= csr_apply(op_i, wbaseptr_q, wdata_i);
                                CSR_MVU_IBASEPTR:
                                        ibaseptr_q <= csr_apply(op_i, ibaseptr_q, wdata_i);
                                CSR_MVU_OBASEPTR:
                                        obaseptr_q <= csr_apply(op_i, obaseptr_q, wdata_i);
                                CSR_MVU_WLENGTH:
                                        wlength_q <= csr_apply(op_i, wlength_q, wdata_i);
                                CSR_MVU_PRECISION:
                                        precision_q <= csr_apply(op_i, precision_q, wdata_i);
                                CSR_MVU_COMMAND:
                                        command_q <= command_new;
                                default: ;
                        endcase
                        start_q <= command_wr && command_new[0];   // One cycle only
                end
        end

        assign mvu_start_o = start_q;
        assign wbaseptr_o  = wbaseptr_q;
        assign ibaseptr_o  = ibaseptr_q;
        assign obaseptr_o  = obaseptr_q;
        assign wlength_o   = wlength_q;
        assign precision_o = precision_q;

endmodule

`default_nettype wire

/* mvu_irq_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module mvu_irq_ctrl
        import mvu_csr_pkg::*;
(
        input  wire             clk,
        input  wire             reset_i,
        input  wire csr_op_t    op_i,
        input  wire csr_addr_t  addr_i,
        input  wire csr_data_t  wdata_i,
        output logic            hit_o,
        output csr_data_t       rdata_o,
        input  wire             mvu_irq_i,
        output logic            irq_evt_o
);

        logic      irq_q;
        logic      irq_d;
        logic      irq_rise;
        logic      pending_q;
        logic      enable_q;
        csr_data_t status_rd;
        csr_data_t ie_rd;
        csr_data_t status_new;
        csr_data_t ie_new;

        // Upper bits are not stored
        assign status_rd  = {{(XLEN-1){1'b0}}, pending_q};
        assign ie_rd      = {{(XLEN-1){1'b0}}, enable_q};
        assign status_new = csr_apply(op_i, status_rd, wdata_i);
        assign ie_new     = csr_apply(op_i, ie_rd, wdata_i);
        assign irq_rise   = irq_q & ~irq_d;

        assign hit_o   = (addr_i == CSR_MVU_STATUS) || (addr_i == CSR_MVU_IE);
        assign rdata_o = (addr_i == CSR_MVU_STATUS) ? status_rd :
                         (addr_i == CSR_MVU_IE)     ? ie_rd     : '0;

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        irq_q     <= 1'b0;
                        irq_d     <= 1'b0;
                        pending_q <= 1'b0;
                        enable_q  <= 1'b0;
                end else begin
                        irq_q <= mvu_irq_i;   // Input register
                        irq_d <= irq_q;
                        if (irq_rise) begin
                                pending_q <= 1'b1;   // Wins over a clear
                        end else if (addr_i == CSR_MVU_STATUS) begin
                                pending_q <= status_new[0];
                        end
                        if (addr_i == CSR_MVU_IE) begin
                                enable_q <= ie_new[0];
                        end
                end
        end

        assign irq_evt_o = pending_q & enable_q;

endmodule

`default_nettype wire

/* hart_csr_file.sv */
`timescale 1ns/10ps
`default_nettype none

module hart_csr_file
        import mvu_csr_pkg::*;
(
        input  wire             clk,
        input  wire             reset_i,
        csr_access_if.responder bus,
        input  wire             mvu_irq_i,
        output logic            mvu_start_o,
        output logic            mvu_irq_evt_o,
        output csr_data_t       wbaseptr_o,
        output csr_data_t       ibaseptr_o,
        output csr_data_t       obaseptr_o,
        output csr_data_t       wlength_o,
        output csr_data_t       precision_o
);

        logic      cfg_hit;
        logic      irq_hit;
        csr_data_t cfg_rdata;
        csr_data_t irq_rdata;
        csr_op_t   cfg_op;
        csr_op_t   irq_op;

        // Op only reaches the block that owns the address
        assign cfg_op = cfg_hit ? bus.op : CSR_OP_NONE;
        assign irq_op = irq_hit ? bus.op : CSR_OP_NONE;

        mvu_cfg_regs cfg_regs (
                .clk         (clk),
                .reset_i     (reset_i),
                .op_i        (cfg_op),
                .addr_i      (bus.addr),
                .wdata_i     (bus.wdata),
                .hit_o       (cfg_hit),
                .rdata_o     (cfg_rdata),
                .mvu_start_o (mvu_start_o),
                .wbaseptr_o  (wbaseptr_o),
                .ibaseptr_o  (ibaseptr_o),
                .obaseptr_o  (obaseptr_o),
                .wlength_o   (wlength_o),
                .precision_o (precision_o)
        );

        mvu_irq_ctrl irq_ctrl (
                .clk       (clk),
                .reset_i   (reset_i),
                .op_i      (irq_op),
                .addr_i    (bus.addr),
                .wdata_i   (bus.wdata),
                .hit_o     (irq_hit),
                .rdata_o   (irq_rdata),
                .mvu_irq_i (mvu_irq_i),
                .irq_evt_o (mvu_irq_evt_o)
        );

        assign bus.rdata   = cfg_hit ? cfg_rdata :
                             irq_hit ? irq_rdata : '0;
        assign bus.illegal = (bus.op != CSR_OP_NONE) && !cfg_hit && !irq_hit;

endmodule

`default_nettype wire

/* mvu_csr_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mvu_csr_top
        import mvu_csr_pkg::*;
#(
        parameter int unsigned NUM_HARTS = 4   // At most 2**HART_ID_WIDTH
) (
        input  wire                       clk,
        input  wire                       reset_i,
        input  wire hart_id_t             hart_id_i,
        input  wire csr_op_t              csr_op_i,
        input  wire csr_addr_t            csr_addr_i,
        input  wire csr_data_t            csr_wdata_i,
        output csr_data_t                 csr_rdata_o,
        output logic                      csr_illegal_o,
        input  wire [NUM_HARTS-1:0]       mvu_irq_i,
        output logic [NUM_HARTS-1:0]      mvu_start_o,
        output logic [NUM_HARTS-1:0]      mvu_irq_evt_o,
        output logic [XLEN*NUM_HARTS-1:0] mvu_wbaseptr_o,
        output logic [XLEN*NUM_HARTS-1:0] mvu_ibaseptr_o,
        output logic [XLEN*NUM_HARTS-1:0] mvu_obaseptr_o,
        output logic [XLEN*NUM_HARTS-1:0] mvu_wlength_o,
        output logic [XLEN*NUM_HARTS-1:0] mvu_precision_o
);

        csr_access_if hart_bus [NUM_HARTS] ();

        hart_csr_router #(
                .NUM_HARTS (NUM_HARTS)
        ) router (
                .hart_id_i     (hart_id_i),
                .csr_op_i      (csr_op_i),
                .csr_addr_i    (csr_addr_i),
                .csr_wdata_i   (csr_wdata_i),
                .csr_rdata_o   (csr_rdata_o),
                .csr_illegal_o (csr_illegal_o),
                .hart_bus      (hart_bus)
        );

        // Hart h owns slice h of every per-hart vector
        for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
                hart_csr_file csr_file (
                        .clk           (clk),
                        .reset_i       (reset_i),
                        .bus           (hart_bus[h]),
                        .mvu_irq_i     (mvu_irq_i[h]),
                        .mvu_start_o   (mvu_start_o[h]),
                        .mvu_irq_evt_o (mvu_irq_evt_o[h]),
                        .wbaseptr_o    (mvu_wbaseptr_o[h*XLEN +: XLEN]),
                        .ibaseptr_o    (mvu_ibaseptr_o[h*XLEN +: XLEN]),
                        .obaseptr_o    (mvu_obaseptr_o[h*XLEN +: XLEN]),
                        .wlength_o     (mvu_wlength_o[h*XLEN +: XLEN]),
                        .precision_o   (mvu_precision_o[h*XLEN +: XLEN])
                );
        end

endmodule

`default_nettype wire

/* tb_mvu_csr_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mvu_csr_top
        import mvu_csr_pkg::*;
();

        localparam int NUM_HARTS = 4;
        localparam int NUM_CFG   = 5;   // Config regs with an output port
        localparam int OUT_W     = NUM_CFG*XLEN*NUM_HARTS;
        localparam int TIMEOUT   = 40;

        logic                      clk;
        logic                      reset;
        hart_id_t                  hart_id;
        csr_op_t                   csr_op;
        csr_addr_t                 csr_addr;
        csr_data_t                 csr_wdata;
        csr_data_t                 csr_rdata;
        logic                      csr_illegal;
        logic [NUM_HARTS-1:0]      mvu_irq;
        logic [NUM_HARTS-1:0]      mvu_start;
        logic [NUM_HARTS-1:0]      mvu_irq_evt;
        logic [XLEN*NUM_HARTS-1:0] mvu_wbaseptr;
        logic [XLEN*NUM_HARTS-1:0] mvu_ibaseptr;
        logic [XLEN*NUM_HARTS-1:0] mvu_obaseptr;
        logic [XLEN*NUM_HARTS-1:0] mvu_wlength;
        logic [XLEN*NUM_HARTS-1:0] mvu_precision;

        // Stimulus table, one entry per clock
        string                row_name    [$];
        hart_id_t             row_hart    [$];
        csr_op_t              row_op      [$];
        csr_addr_t            row_addr    [$];
        csr_data_t            row_wdata   [$];
        logic [NUM_HARTS-1:0] row_irq     [$];
        csr_data_t            row_rdata   [$];
        logic                 row_illegal [$];
        logic [NUM_HARTS-1:0] row_start   [$];
        logic [NUM_HARTS-1:0] row_evt     [$];
        logic [OUT_W-1:0]     row_outs    [$];

        // Reference model state
        csr_data_t            m_regs [NUM_HARTS][6];
        logic [NUM_HARTS-1:0] m_pend;
        logic [NUM_HARTS-1:0] m_en;
        logic [NUM_HARTS-1:0] m_start;
        logic [NUM_HARTS-1:0] m_irq_q;
        logic [NUM_HARTS-1:0] m_irq_d;

        mvu_csr_top #(
                .NUM_HARTS (NUM_HARTS)
        ) uut (
                .clk             (clk),
                .reset_i         (reset),
                .hart_id_i       (hart_id),
                .csr_op_i        (csr_op),
                .csr_addr_i      (csr_addr),
                .csr_wdata_i     (csr_wdata),
                .csr_rdata_o     (csr_rdata),
                .csr_illegal_o   (csr_illegal),
                .mvu_irq_i       (mvu_irq),
                .mvu_start_o     (mvu_start),
                .mvu_irq_evt_o   (mvu_irq_evt),
                .mvu_wbaseptr_o  (mvu_wbaseptr),
                .mvu_ibaseptr_o  (mvu_ibaseptr),
                .mvu_obaseptr_o  (mvu_obaseptr),
                .mvu_wlength_o   (mvu_wlength),
                .mvu_precision_o (mvu_precision)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        function automatic csr_data_t model_update(input csr_op_t op, input csr_data_t old_val,
                                                   input csr_data_t wdata);
                if (op == CSR_OP_WRITE)
                        return wdata;
                if (op == CSR_OP_SET)
                        return old_val | wdata;
                if (op == CSR_OP_CLEAR)
                        return old_val & ~wdata;
                return old_val;
        endfunction

        function automatic csr_addr_t reg_addr(input int offset);
                return csr_addr_t'(int'(CSR_MVU_WBASEPTR) + offset);
        endfunction

        function automatic string field_name(input int f);
                case (f)
                        0:       return "wbaseptr";
                        1:       return "ibaseptr";
                        2:       return "obaseptr";
                        3:       return "wlength";
                        default: return "precision";
                endcase
        endfunction

        task automatic compare(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
                if (actual !== expected) begin
                        $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
                        $display("ERRORS FOUND");
                        $fatal(1, "Value check failed");
                end
        endtask

        // Expected values come from the model state before this row's clock edge
        task automatic add_row(input string name, input int hart, input csr_op_t op,
                               input csr_addr_t addr, input csr_data_t wdata,
                               input logic [NUM_HARTS-1:0] irq);
                csr_data_t            rd;
                csr_data_t            nv;
                logic [NUM_HARTS-1:0] rise;
                logic [OUT_W-1:0]     snap;
                logic                 hit;
                int                   idx;
                idx = int'(addr) - int'(CSR_MVU_WBASEPTR);
                hit = (hart < NUM_HARTS) && (idx >= 0) && (idx < 8);
                rd  = '0;
                for (int f = 0; f < NUM_CFG; f++) begin
                        for (int h = 0; h < NUM_HARTS; h++) begin
                                snap[(f*NUM_HARTS+h)*XLEN +: XLEN] = m_regs[h][f];
                        end
                end
                if (hit && idx < 6)
                        rd = m_regs[hart][idx];
                else if (hit && idx == 6)
                        rd = csr_data_t'(m_pend[hart]);
                else if (hit)
                        rd = csr_data_t'(m_en[hart]);
                row_name.push_back(name);
                row_hart.push_back(hart_id_t'(hart));
                row_op.push_back(op);
                row_addr.push_back(addr);
                row_wdata.push_back(wdata);
                row_irq.push_back(irq);
                row_rdata.push_back(rd);
                row_illegal.push_back((op != CSR_OP_NONE) && !hit);
                row_start.push_back(m_start);
                row_evt.push_back(m_pend & m_en);
                row_outs.push_back(snap);
                rise    = m_irq_q & ~m_irq_d;   // Edge seen by the input pipeline
                m_start = '0;
                if (hit && (op == CSR_OP_WRITE || op == CSR_OP_SET || op == CSR_OP_CLEAR)) begin
                        nv = model_update(op, rd, wdata);
                        if (idx < 6)
                                m_regs[hart][idx] = nv;
                        if (idx == 5)
                                m_start[hart] = nv[0];
                        if (idx == 6)
                                m_pend[hart] = nv[0];
                        if (idx == 7)
                                m_en[hart] = nv[0];
                end
                m_pend  = m_pend | rise;
                m_irq_d = m_irq_q;
                m_irq_q = irq;
        endtask

        task automatic build_table();
                csr_op_t ops [3];
                ops = '{CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR};
                for (int h = 0; h < NUM_HARTS; h++) begin
                        for (int a = 0; a < 8; a++) begin
                                add_row($sformatf("reset read h%0d a%0d", h, a), h, CSR_OP_READ,
                                        reg_addr(a), '0, '0);
                        end
                end
                for (int k = 0; k < 3; k++) begin
                        for (int h = 0; h < NUM_HARTS; h++) begin
                                for (int a = 0; a < NUM_CFG; a++) begin
                                        add_row($sformatf("op%0d h%0d a%0d", ops[k], h, a), h,
                                                ops[k], reg_addr(a), $urandom(), '0);
                                end
                        end
                        for (int h = 0; h < NUM_HARTS; h++) begin
                                for (int a = 0; a < NUM_CFG; a++) begin
                                        add_row($sformatf("readback op%0d h%0d a%0d", ops[k], h, a),
                                                h, CSR_OP_READ, reg_addr(a), '0, '0);
                                end
                        end
                end
                add_row("read keeps value", 1, CSR_OP_READ, CSR_MVU_WBASEPTR, $urandom(), '0);
                add_row("none keeps value", 1, CSR_OP_NONE, CSR_MVU_WBASEPTR, $urandom(), '0);
                add_row("unmapped f28", 0, CSR_OP_WRITE, 12'hF28, $urandom(), '0);
                add_row("unmapped f1f", 1, CSR_OP_SET, 12'hF1F, $urandom(), '0);
                add_row("unmapped 300", 2, CSR_OP_READ, 12'h300, '0, '0);
                add_row("hart 4 write", 4, CSR_OP_WRITE, CSR_MVU_WBASEPTR, $urandom(), '0);
                add_row("hart 7 read", 7, CSR_OP_READ, CSR_MVU_IBASEPTR, '0, '0);
                add_row("hart 5 none", 5, CSR_OP_NONE, CSR_MVU_WBASEPTR, '0, '0);
                add_row("after illegal h0", 0, CSR_OP_READ, CSR_MVU_WBASEPTR, '0, '0);
                add_row("cmd start h2", 2, CSR_OP_WRITE, CSR_MVU_COMMAND, 32'h1, '0);
                add_row("cmd pulse h2", 2, CSR_OP_NONE, CSR_MVU_COMMAND, '0, '0);
                add_row("cmd pulse gone h2", 2, CSR_OP_READ, CSR_MVU_COMMAND, '0, '0);
                add_row("cmd no start h2", 2, CSR_OP_WRITE, CSR_MVU_COMMAND, 32'h10, '0);
                add_row("cmd no pulse h2", 2, CSR_OP_READ, CSR_MVU_COMMAND, '0, '0);
                add_row("cmd set h0", 0, CSR_OP_SET, CSR_MVU_COMMAND, 32'h1, '0);
                add_row("cmd pulse h0", 0, CSR_OP_READ, CSR_MVU_COMMAND, '0, '0);
                add_row("cmd read h0", 0, CSR_OP_READ, CSR_MVU_COMMAND, '0, '0);
                add_row("ie write h1", 1, CSR_OP_WRITE, CSR_MVU_IE, 32'hFFFF_FFFF, '0);
                add_row("ie read h1", 1, CSR_OP_READ, CSR_MVU_IE, '0, '0);
                add_row("status set h0", 0, CSR_OP_SET, CSR_MVU_STATUS, 32'h1, '0);
                add_row("ie write h0", 0, CSR_OP_WRITE, CSR_MVU_IE, 32'h1, '0);
                add_row("status read h0", 0, CSR_OP_READ, CSR_MVU_STATUS, '0, '0);
                add_row("status clear h0", 0, CSR_OP_CLEAR, CSR_MVU_STATUS, 32'h1, '0);
                add_row("status cleared h0", 0, CSR_OP_READ, CSR_MVU_STATUS, '0, '0);
                for (int n = 0; n < 4; n++) begin
                        add_row($sformatf("irq high h3 %0d", n), 0, CSR_OP_READ, CSR_MVU_IE,
                                '0, 4'b1000);   // IE of hart 3 stays clear
                end
        endtask

        task automatic apply_access(input hart_id_t hart, input csr_op_t op, input csr_addr_t addr,
                                    input csr_data_t wdata, input logic [NUM_HARTS-1:0] irq);
                @(posedge clk);
                hart_id   <= hart;
                csr_op    <= op;
                csr_addr  <= addr;
                csr_wdata <= wdata;
                mvu_irq   <= irq;
                @(negedge clk);
        endtask

        task automatic run_row(input int i);
                logic [OUT_W-1:0] outs;
                apply_access(row_hart[i], row_op[i], row_addr[i], row_wdata[i], row_irq[i]);
                outs = {mvu_precision, mvu_wlength, mvu_obaseptr, mvu_ibaseptr, mvu_wbaseptr};
                compare({row_name[i], " rdata"}, row_rdata[i], csr_rdata);
                compare({row_name[i], " illegal"}, row_illegal[i], csr_illegal);
                compare({row_name[i], " start"}, row_start[i], mvu_start);
                compare({row_name[i], " irq_evt"}, row_evt[i], mvu_irq_evt);
                for (int f = 0; f < NUM_CFG; f++) begin
                        for (int h = 0; h < NUM_HARTS; h++) begin
                                compare($sformatf("%s %s h%0d", row_name[i], field_name(f), h),
                                        row_outs[i][(f*NUM_HARTS+h)*XLEN +: XLEN],
                                        outs[(f*NUM_HARTS+h)*XLEN +: XLEN]);
                        end
                end
        endtask

        task automatic wait_pending(input hart_id_t hart, input logic [NUM_HARTS-1:0] irq);
                int   n;
                logic seen;
                n    = 0;
                seen = 1'b0;
                while (!seen && n < TIMEOUT) begin
                        apply_access(hart, CSR_OP_READ, CSR_MVU_STATUS, '0, irq);
                        seen = csr_rdata[0];
                        n++;
                end
                if (!seen) begin
                        $display("Timeout: pending bit of hart %0d was never set", hart);
                        $display("ERRORS FOUND");
                        $fatal(1, "Timeout");
                end
                compare($sformatf("status pending h%0d", hart), 32'h1, csr_rdata);
        endtask

        initial begin
                reset     = 1'b1;
                hart_id   = '0;
                csr_op    = CSR_OP_NONE;
                csr_addr  = '0;
                csr_wdata = '0;
                mvu_irq   = '0;
                m_pend    = '0;
                m_en      = '0;
                m_start   = '0;
                m_irq_q   = '0;
                m_irq_d   = '0;
                for (int h = 0; h < NUM_HARTS; h++) begin
                        for (int r = 0; r < 6; r++) begin
                                m_regs[h][r] = '0;
                        end
                end
                void'($urandom(32'h96c9_a8fa));
                build_table();
                repeat (4) @(posedge clk);
                reset <= 1'b0;
                @(negedge clk);
                compare("start after reset", '0, mvu_start);
                compare("irq_evt after reset", '0, mvu_irq_evt);
                for (int i = 0; i < row_name.size(); i++) begin
                        run_row(i);
                end
                // Edge on hart 1 with IE set, hart 3 still high and masked
                apply_access(1, CSR_OP_NONE, CSR_MVU_STATUS, '0, 4'b1010);
                wait_pending(1, 4'b1010);
                compare("irq_evt after edge h1", 32'h2, mvu_irq_evt);
                wait_pending(3, 4'b1010);
                compare("irq_evt masked h3", 32'h2, mvu_irq_evt);
                apply_access(1, CSR_OP_CLEAR, CSR_MVU_STATUS, 32'h1, 4'b1010);
                apply_access(1, CSR_OP_READ, CSR_MVU_STATUS, '0, 4'b1010);
                compare("status cleared h1", '0, csr_rdata);
                compare("irq_evt after clear h1", '0, mvu_irq_evt);
                $display("NO ERRORS");
                $finish;
        end

endmodule

`default_nettype wire

/* vlog.f */
mvu_csr_pkg.sv
csr_access_if.sv
hart_csr_router.sv
mvu_cfg_regs.sv
mvu_irq_ctrl.sv
hart_csr_file.sv
mvu_csr_top.sv
tb_mvu_csr_top.sv

/* Bender.yml */
package:
  name: mvu_csr

sources:
  - files:
      - mvu_csr_pkg.sv
      - csr_access_if.sv
      - hart_csr_router.sv
      - mvu_cfg_regs.sv
      - mvu_irq_ctrl.sv
      - hart_csr_file.sv
      - mvu_csr_top.sv
  - target: test
    files:
      - tb_mvu_csr_top.sv
